// ==== filelist.f ====
logic/comm_pkg.sv
logic/mem_pkg.sv
logic/word_link.sv
logic/cmd_sequencer.sv
logic/mem_port.sv
logic/comm_bridge_top.sv
sim/comm_bridge_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = comm_bridge_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/comm_bridge_tb.sv ====
module comm_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import comm_pkg::*;
	import mem_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int PURGE_WORDS = 6;
	localparam int SYNC_WORDS  = 8;
	localparam int READ_WORDS  = 5;
	localparam int WRITE_WORDS = 12;
	// receive words of all tests, headers and terminators included
	localparam int TEST_WORDS = PURGE_WORDS + SYNC_WORDS + 1 + 4 + (3 + READ_WORDS) +
		(3 + WRITE_WORDS) + 4;
	localparam int WATCHDOG_CYCLES = PURGE_CYCLES + 400 * TEST_WORDS;

	logic      clock = 1'b0;
	logic      resetn;
	logic      rx_empty;
	word_t     rx_data;
	logic      rx_read;
	logic      tx_full;
	logic      tx_write;
	word_t     tx_data;
	logic      mem_ready;
	logic      mem_req;
	logic      mem_rw;
	mem_addr_t mem_addr;
	mem_data_t mem_wdata;
	logic      mem_done;
	mem_data_t mem_rdata;
	logic      mem_clear;
	logic      exception;

	// host FIFO and memory models
	word_t       rx_q[$];
	mem_data_t   mem_model[mem_addr_t];
	logic        mem_busy;
	logic        busy_rw;
	mem_addr_t   busy_addr;
	mem_data_t   busy_data;
	int          busy_delay;
	logic        stress = 1'b0;
	logic [31:0] lfsr_state = 32'h78d941dd;

	// DUT outputs sampled on the falling edge
	logic      seen_rx_read = 1'b0;
	logic      seen_req = 1'b0;
	logic      seen_clear = 1'b0;
	logic      seen_rw;
	mem_addr_t seen_addr;
	mem_data_t seen_data;

	// expected results
	word_t     exp_tx[$];
	logic      exp_rw[$];
	mem_addr_t exp_addr[$];
	mem_data_t exp_wdata[$];
	mem_data_t ref_mem[mem_addr_t];
	string     test_name = "reset";
	logic      exc_allowed = 1'b0;
	logic      exc_sticky = 1'b0;

	always begin
		#(CLK_PERIOD / 2);
		clock = ~clock;
	end

	comm_bridge_top i_comm_bridge_top (
		.clock_i     (clock),
		.resetn_i    (resetn),
		.rx_empty_i  (rx_empty),
		.rx_data_i   (rx_data),
		.rx_read_o   (rx_read),
		.tx_full_i   (tx_full),
		.tx_write_o  (tx_write),
		.tx_data_o   (tx_data),
		.mem_ready_i (mem_ready),
		.mem_req_o   (mem_req),
		.mem_rw_o    (mem_rw),
		.mem_addr_o  (mem_addr),
		.mem_data_o  (mem_wdata),
		.mem_done_i  (mem_done),
		.mem_data_i  (mem_rdata),
		.mem_clear_o (mem_clear),
		.exception_o (exception)
	);

	// ------------------------------------------------------------
	// random source, galois LFSR
	// ------------------------------------------------------------
	function automatic logic next_rand_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], next_rand_bit()};
		end
		return value;
	endfunction

	// unwritten memory, mixes every address bit
	function automatic mem_data_t fill_word(input mem_addr_t addr);
		return {addr, 5'h15} ^ 32'h9e37_79b9;
	endfunction

	// ------------------------------------------------------------
	// reference model of one command
	// ------------------------------------------------------------
	function automatic void predict_command(input logic is_write, input int n,
		input mem_addr_t addr, input word_t data[$]);
		mem_addr_t a;
		a = addr;
		for (int i = 0; i < n; i++) begin
			exp_rw.push_back(is_write);
			exp_addr.push_back(a);
			if (is_write) begin
				exp_wdata.push_back(data[i]);
				ref_mem[a] = data[i];
			end else begin
				exp_wdata.push_back('0);
				exp_tx.push_back(ref_mem.exists(a) ? ref_mem[a] : fill_word(a));
			end
			a = a + WORD_STEP;
		end
		// writes close with a zero word
		if (is_write) begin
			exp_tx.push_back('0);
		end
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic send_command(input logic is_write, input int n, input mem_addr_t addr,
		input word_t data[$]);
		word_t cmd;
		cmd = '0;
		cmd[WRITE_FLAG_BIT] = is_write;
		if (n != 1) begin
			cmd[COUNT_FLAG_BIT] = 1'b1;
			cmd[COUNT_WIDTH-1:0] = n[COUNT_WIDTH-1:0];
		end
		rx_q.push_back('0);
		rx_q.push_back(cmd);
		rx_q.push_back({5'b0, addr});
		foreach (data[i]) begin
			rx_q.push_back(data[i]);
		end
		predict_command(is_write, n, addr, data);
	endtask

	task automatic wait_idle();
		while (rx_q.size() != 0 || exp_tx.size() != 0 || exp_rw.size() != 0 || mem_busy) begin
			@(posedge clock);
		end
	endtask

	// ------------------------------------------------------------
	// input drivers, 2 ns after the rising edge
	// ------------------------------------------------------------
	initial begin : drive
		rx_empty   = 1'b1;
		rx_data    = '0;
		tx_full    = 1'b0;
		mem_ready  = 1'b0;
		mem_done   = 1'b0;
		mem_rdata  = '0;
		mem_busy   = 1'b0;
		busy_delay = 0;
		forever begin
			@(posedge clock);
			#2;
			if (seen_rx_read) begin
				void'(rx_q.pop_front());
			end
			if (seen_clear) begin
				if (busy_rw) begin
					mem_model[busy_addr] = busy_data;
				end
				mem_done = 1'b0;
				mem_busy = 1'b0;
			end else if (mem_busy && !mem_done) begin
				if (busy_delay == 1) begin
					mem_done  = 1'b1;
					mem_rdata = mem_model.exists(busy_addr) ? mem_model[busy_addr] :
						fill_word(busy_addr);
				end else begin
					busy_delay = busy_delay - 1;
				end
			end
			if (seen_req) begin
				mem_busy   = 1'b1;
				busy_rw    = seen_rw;
				busy_addr  = seen_addr;
				busy_data  = seen_data;
				busy_delay = int'(rand_bits(2)) + 1;
			end
			rx_empty = rx_q.size() == 0;
			if (stress && next_rand_bit()) begin
				rx_empty = 1'b1;
			end
			rx_data = (rx_q.size() != 0) ? rx_q[0] : '0;
			if (stress) begin
				tx_full   = next_rand_bit();
				mem_ready = next_rand_bit();
			end else begin
				tx_full   = next_rand_bit() & next_rand_bit();
				mem_ready = next_rand_bit() | next_rand_bit();
			end
		end
	end

	// ------------------------------------------------------------
	// compare process, falling edge
	// ------------------------------------------------------------
	always @(negedge clock) begin : compare
		logic      exp_is_write;
		mem_data_t exp_data;
		seen_rx_read = rx_read === 1'b1;
		seen_req     = mem_req === 1'b1;
		seen_clear   = mem_clear === 1'b1;
		seen_rw      = mem_rw;
		seen_addr    = mem_addr;
		seen_data    = mem_wdata;
		if (resetn) begin
			check_flag({test_name, " rx read while empty"}, 1'b0, rx_read & rx_empty);
			check_flag({test_name, " tx write while full"}, 1'b0, tx_write & tx_full);
			// done is only raised for an access in flight, first done cycle clears
			check_flag({test_name, " clear"}, mem_done, mem_clear);
			if (tx_write) begin
				if (exp_tx.size() == 0) begin
					$display("unexpected transmit word %h during %s", tx_data, test_name);
					abort_run();
				end
				check_word(test_name, exp_tx.pop_front(), tx_data);
			end
			if (mem_req) begin
				if (exp_rw.size() == 0) begin
					$display("unexpected memory request at %h during %s", mem_addr, test_name);
					abort_run();
				end
				exp_is_write = exp_rw.pop_front();
				exp_data     = exp_wdata.pop_front();
				check_flag({test_name, " rw"}, exp_is_write, mem_rw);
				check_addr(test_name, exp_addr.pop_front(), mem_addr);
				if (exp_is_write) begin
					check_word(test_name, exp_data, mem_wdata);
				end
			end
			if (!exc_allowed) begin
				check_flag({test_name, " exception"}, 1'b0, exception);
			end
			// sticky until reset
			if (exc_sticky) begin
				check_flag({test_name, " exception held"}, 1'b1, exception);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the DUT stopped responding",
			WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin : main
		word_t     sync_word;
		word_t     wdata[$];
		mem_addr_t write_addr;
		mem_addr_t base;
		mem_addr_t step_addr;
		resetn = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		resetn = 1'b1;

		// stale words, all swallowed
		test_name = "purge";
		for (int i = 0; i < PURGE_WORDS; i++) begin
			rx_q.push_back(rand_bits(32));
		end
		while (rx_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (PURGE_CYCLES + 8) @(posedge clock);

		test_name = "sync";
		for (int i = 0; i < SYNC_WORDS; i++) begin
			sync_word = rand_bits(32);
			if (sync_word == KEY_SYNC) begin
				sync_word = ~sync_word;
			end
			rx_q.push_back(sync_word);
			exp_tx.push_back(sync_word ^ XOR_SYNC);
		end
		rx_q.push_back(KEY_SYNC);
		wait_idle();

		test_name = "single write";
		write_addr = mem_addr_t'(rand_bits(25) << 2);
		wdata.push_back(rand_bits(32));
		send_command(1'b1, 1, write_addr, wdata);
		wait_idle();

		// window covers the word just written
		test_name = "counted read";
		base = write_addr - mem_addr_t'(8);
		wdata.delete();
		send_command(1'b0, READ_WORDS, base, wdata);
		wait_idle();

		test_name = "counted write";
		stress = 1'b1;
		base = mem_addr_t'(rand_bits(25) << 2);
		for (int i = 0; i < WRITE_WORDS; i++) begin
			wdata.push_back(rand_bits(32));
		end
		send_command(1'b1, WRITE_WORDS, base, wdata);
		wait_idle();
		stress = 1'b0;
		step_addr = base;
		for (int i = 0; i < WRITE_WORDS; i++) begin
			if (!mem_model.exists(step_addr)) begin
				$display("counted write left no word at address %h", step_addr);
				abort_run();
			end
			check_word({test_name, " memory"}, ref_mem[step_addr], mem_model[step_addr]);
			step_addr = step_addr + WORD_STEP;
		end

		test_name = "bad terminator";
		exc_allowed = 1'b1;
		rx_q.push_back(rand_bits(32) | 32'h1);
		while (exception !== 1'b1) begin
			@(posedge clock);
		end
		exc_sticky = 1'b1;
		while (rx_q.size() != 0) begin
			@(posedge clock);
		end
		// a valid read that must stay unserved
		rx_q.push_back('0);
		rx_q.push_back('0);
		rx_q.push_back({5'b0, base});
		repeat (50) @(posedge clock);
		if (rx_q.size() != 3) begin
			$display("receive words were taken after the exception");
			abort_run();
		end

		if (exp_tx.size() != 0 || exp_rw.size() != 0) begin
			$display("%0d transmit words and %0d memory requests never appeared",
				exp_tx.size(), exp_rw.size());
			abort_run();
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// ==== logic/comm_bridge_top.sv ====
module comm_bridge_top (
	input  logic               clock_i,
	input  logic               resetn_i,
	// host FIFOs
	input  logic               rx_empty_i,
	input  comm_pkg::word_t    rx_data_i,
	output logic               rx_read_o,
	input  logic               tx_full_i,
	output logic               tx_write_o,
	output comm_pkg::word_t    tx_data_o,
	// memory bus
	input  logic               mem_ready_i,
	output logic               mem_req_o,
	output logic               mem_rw_o,
	output mem_pkg::mem_addr_t mem_addr_o,
	output mem_pkg::mem_data_t mem_data_o,
	input  logic               mem_done_i,
	input  mem_pkg::mem_data_t mem_data_i,
	output logic               mem_clear_o,
	output logic               exception_o
);

	import comm_pkg::*;
	import mem_pkg::*;

	// ------------------------------------------------------------
	// link to sequencer
	// ------------------------------------------------------------
	logic      get_req;
	logic      get_valid;
	word_t     get_word;
	logic      put_req;
	word_t     put_word;
	logic      put_done;

	// ------------------------------------------------------------
	// sequencer to memory port
	// ------------------------------------------------------------
	logic      acc_start;
	mem_op_e   acc_op;
	mem_addr_t acc_addr;
	mem_data_t acc_wdata;
	logic      acc_done;
	mem_data_t acc_rdata;

	word_link i_word_link (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.rx_empty_i  (rx_empty_i),
		.rx_data_i   (rx_data_i),
		.rx_read_o   (rx_read_o),
		.tx_full_i   (tx_full_i),
		.tx_write_o  (tx_write_o),
		.tx_data_o   (tx_data_o),
		.get_req_i   (get_req),
		.get_valid_o (get_valid),
		.get_word_o  (get_word),
		.put_req_i   (put_req),
		.put_word_i  (put_word),
		.put_done_o  (put_done)
	);

	cmd_sequencer i_cmd_sequencer (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.get_req_o   (get_req),
		.get_valid_i (get_valid),
		.get_word_i  (get_word),
		.put_req_o   (put_req),
		.put_word_o  (put_word),
		.put_done_i  (put_done),
		.acc_start_o (acc_start),
		.acc_op_o    (acc_op),
		.acc_addr_o  (acc_addr),
		.acc_wdata_o (acc_wdata),
		.acc_done_i  (acc_done),
		.acc_rdata_i (acc_rdata),
		.exception_o (exception_o)
	);

	mem_port i_mem_port (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.acc_start_i (acc_start),
		.acc_op_i    (acc_op),
		.acc_addr_i  (acc_addr),
		.acc_wdata_i (acc_wdata),
		.acc_done_o  (acc_done),
		.acc_rdata_o (acc_rdata),
		.mem_ready_i (mem_ready_i),
		.mem_req_o   (mem_req_o),
		.mem_rw_o    (mem_rw_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.mem_done_i  (mem_done_i),
		.mem_data_i  (mem_data_i),
		.mem_clear_o (mem_clear_o)
	);

endmodule

// ==== logic/mem_port.sv ====
module mem_port (
	input  logic               clock_i,
	input  logic               resetn_i,
	// access from the sequencer
	input  logic               acc_start_i,
	input  mem_pkg::mem_op_e   acc_op_i,
	input  mem_pkg::mem_addr_t acc_addr_i,
	input  mem_pkg::mem_data_t acc_wdata_i,
	output logic               acc_done_o,
	output mem_pkg::mem_data_t acc_rdata_o,
	// memory bus
	input  logic               mem_ready_i,
	output logic               mem_req_o,
	output logic               mem_rw_o,
	output mem_pkg::mem_addr_t mem_addr_o,
	output mem_pkg::mem_data_t mem_data_o,
	input  logic               mem_done_i,
	input  mem_pkg::mem_data_t mem_data_i,
	output logic               mem_clear_o
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_WAIT_READY,
		PORT_WAIT_DONE
	} port_state_e;

	port_state_e state_q;
	logic        done_q;
	mem_op_e     op_q;
	mem_addr_t   addr_q;
	mem_data_t   wdata_q;
	mem_data_t   rdata_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= PORT_IDLE;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				PORT_IDLE: begin
					if (acc_start_i) begin
						state_q <= PORT_WAIT_READY;
					end
				end
				PORT_WAIT_READY: begin
					if (mem_ready_i) begin
						state_q <= PORT_WAIT_DONE;
					end
				end
				PORT_WAIT_DONE: begin
					if (mem_done_i) begin
						state_q <= PORT_IDLE;
						done_q  <= 1'b1;
					end
				end
				default: begin
					state_q <= PORT_IDLE;
				end
			endcase
		end
	end

	// hold request fields for the whole access
	always_ff @(posedge clock_i) begin
		if (state_q == PORT_IDLE && acc_start_i) begin
			op_q    <= acc_op_i;
			addr_q  <= acc_addr_i;
			wdata_q <= acc_wdata_i;
		end
		if (mem_clear_o && op_q == MEM_READ) begin
			rdata_q <= mem_data_i;
		end
	end

	assign mem_req_o   = state_q == PORT_WAIT_READY && mem_ready_i;
	assign mem_clear_o = state_q == PORT_WAIT_DONE && mem_done_i;
	assign mem_rw_o    = op_q == MEM_WRITE;
	assign mem_addr_o  = addr_q;
	assign mem_data_o  = wdata_q;
	assign acc_done_o  = done_q;
	assign acc_rdata_o = rdata_q;

	a_req_fields_stable: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |=> ($stable(mem_addr_o) && $stable(mem_rw_o)) throughout mem_done_i [->1]);

	// a new access only once the previous one has ended
	a_one_access_in_flight: assert property (@(posedge clock_i) disable iff (!resetn_i)
		acc_start_i |-> state_q == PORT_IDLE);

endmodule

// ==== logic/cmd_sequencer.sv ====
module cmd_sequencer (
	input  logic               clock_i,
	input  logic               resetn_i,
	// word link
	output logic               get_req_o,
	input  logic               get_valid_i,
	input  comm_pkg::word_t    get_word_i,
	output logic               put_req_o,
	output comm_pkg::word_t    put_word_o,
	input  logic               put_done_i,
	// memory access
	output logic               acc_start_o,
	output mem_pkg::mem_op_e   acc_op_o,
	output mem_pkg::mem_addr_t acc_addr_o,
	output mem_pkg::mem_data_t acc_wdata_o,
	input  logic               acc_done_i,
	input  mem_pkg::mem_data_t acc_rdata_i,
	output logic               exception_o
);

	import comm_pkg::*;
	import mem_pkg::*;

	seq_state_e             state_q;
	logic                   start_q;
	logic                   write_q;
	logic [COUNT_WIDTH-1:0] count_q;
	mem_addr_t              addr_q;
	mem_data_t              wdata_q;

	logic [COUNT_WIDTH-1:0] count_field;
	logic                   bad_flags;
	logic                   bad_count;
	logic                   last_word;
	logic                   next_word;

	assign count_field = get_word_i[COUNT_WIDTH-1:0];
	assign bad_flags   = (get_word_i & FLAG_FIELD) != '0;
	assign bad_count   = get_word_i[COUNT_FLAG_BIT] && count_field == '0;
	assign last_word   = count_q == COUNT_WIDTH'(1);

	// word finished and more to go
	assign next_word = !last_word &&
		((state_q == ACCESS && acc_done_i && write_q) ||
		(state_q == RETURN_DATA && put_done_i));

	// ------------------------------------------------------------
	// command FSM
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state_q)
				IDLE: begin
					// zero terminator must lead every command
					if (get_valid_i) begin
						state_q <= (get_word_i != '0) ? ERROR : COMMAND;
					end
				end
				COMMAND: begin
					if (get_valid_i) begin
						state_q <= (bad_flags || bad_count) ? ERROR : ADDRESS;
					end
				end
				ADDRESS: begin
					if (get_valid_i) begin
						state_q <= STEP;
					end
				end
				STEP: begin
					if (write_q) begin
						state_q <= FETCH_DATA;
					end else begin
						start_q <= 1'b1;
						state_q <= ACCESS;
					end
				end
				FETCH_DATA: begin
					if (get_valid_i) begin
						start_q <= 1'b1;
						state_q <= ACCESS;
					end
				end
				ACCESS: begin
					if (acc_done_i) begin
						if (!write_q) begin
							state_q <= RETURN_DATA;
						end else begin
							state_q <= last_word ? ACKNOWLEDGE : STEP;
						end
					end
				end
				RETURN_DATA: begin
					// reads end without an acknowledge
					if (put_done_i) begin
						state_q <= last_word ? IDLE : STEP;
					end
				end
				ACKNOWLEDGE: begin
					if (put_done_i) begin
						state_q <= IDLE;
					end
				end
				ERROR: begin
					state_q <= ERROR;
				end
				default: begin
					state_q <= ERROR;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// command, counter and address registers
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == COMMAND && get_valid_i) begin
			write_q <= get_word_i[WRITE_FLAG_BIT];
			count_q <= get_word_i[COUNT_FLAG_BIT] ? count_field : COUNT_WIDTH'(1);
		end
		if (state_q == ADDRESS && get_valid_i) begin
			addr_q <= get_word_i[MEM_ADDR_WIDTH-1:0];
		end
		if (state_q == FETCH_DATA && get_valid_i) begin
			wdata_q <= get_word_i;
		end
		if (next_word) begin
			count_q <= count_q - 1'b1;
			addr_q  <= addr_q + WORD_STEP;
		end
	end

	assign get_req_o = state_q == IDLE || state_q == COMMAND ||
		state_q == ADDRESS || state_q == FETCH_DATA;
	assign put_req_o  = state_q == RETURN_DATA || state_q == ACKNOWLEDGE;
	// zero word doubles as the write acknowledge
	assign put_word_o = (state_q == RETURN_DATA) ? acc_rdata_i : '0;

	assign acc_start_o = start_q;
	assign acc_op_o    = write_q ? MEM_WRITE : MEM_READ;
	assign acc_addr_o  = addr_q;
	assign acc_wdata_o = wdata_q;

	assign exception_o = state_q == ERROR;

endmodule

// ==== logic/word_link.sv ====
module word_link (
	input  logic             clock_i,
	input  logic             resetn_i,
	// receive FIFO, show-ahead
	input  logic             rx_empty_i,
	input  comm_pkg::word_t  rx_data_i,
	output logic             rx_read_o,
	// transmit FIFO
	input  logic             tx_full_i,
	output logic             tx_write_o,
	output comm_pkg::word_t  tx_data_o,
	// sequencer side
	input  logic             get_req_i,
	output logic             get_valid_o,
	output comm_pkg::word_t  get_word_o,
	input  logic             put_req_i,
	input  comm_pkg::word_t  put_word_i,
	output logic             put_done_o
);

	import comm_pkg::*;

	link_state_e                state_q;
	logic [PURGE_CNT_WIDTH-1:0] purge_cnt_q;

	// ------------------------------------------------------------
	// link state and purge counter
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= PURGE;
			purge_cnt_q <= PURGE_CNT_WIDTH'(PURGE_CYCLES);
		end else begin
			case (state_q)
				PURGE: begin
					// any word seen restarts the quiet period
					if (!rx_empty_i) begin
						purge_cnt_q <= PURGE_CNT_WIDTH'(PURGE_CYCLES);
					end else if (purge_cnt_q != '0) begin
						purge_cnt_q <= purge_cnt_q - 1'b1;
					end else begin
						state_q <= SYNC;
					end
				end
				SYNC: begin
					if (!rx_empty_i && !tx_full_i && rx_data_i == KEY_SYNC) begin
						state_q <= RUN;
					end
				end
				RUN: begin
					state_q <= RUN;
				end
				default: begin
					state_q <= PURGE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// FIFO strobes, same cycle as the FIFO condition
	// ------------------------------------------------------------
	always_comb begin
		rx_read_o   = 1'b0;
		tx_write_o  = 1'b0;
		tx_data_o   = '0;
		get_valid_o = 1'b0;
		put_done_o  = 1'b0;
		case (state_q)
			PURGE: begin
				// discard stale words
				rx_read_o = !rx_empty_i;
			end
			SYNC: begin
				// echo needs room in tx, key gets no reply
				if (!rx_empty_i && !tx_full_i) begin
					rx_read_o = 1'b1;
					if (rx_data_i != KEY_SYNC) begin
						tx_write_o = 1'b1;
						tx_data_o  = rx_data_i ^ XOR_SYNC;
					end
				end
			end
			RUN: begin
				if (get_req_i && !rx_empty_i) begin
					rx_read_o   = 1'b1;
					get_valid_o = 1'b1;
				end
				if (put_req_i && !tx_full_i) begin
					tx_write_o = 1'b1;
					tx_data_o  = put_word_i;
					put_done_o = 1'b1;
				end
			end
			default: begin
				rx_read_o = 1'b0;
			end
		endcase
	end

	// head word is valid whenever get_valid_o is
	assign get_word_o = rx_data_i;

	a_no_read_when_empty: assert property (@(posedge clock_i) disable iff (!resetn_i)
		rx_read_o |-> !rx_empty_i);

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// ------------------------------------------------------------
	// memory bus widths
	// ------------------------------------------------------------
	// byte address, 128MB space
	localparam int MEM_ADDR_WIDTH = 27;
	localparam int MEM_DATA_WIDTH = 32;

	typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
	typedef logic [MEM_DATA_WIDTH-1:0] mem_data_t;

	// one 32-bit word per step
	localparam mem_addr_t WORD_STEP = 4;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

endpackage

// ==== logic/comm_pkg.sv ====
package comm_pkg;

	// ------------------------------------------------------------
	// host link words and sync constants
	// ------------------------------------------------------------
	typedef logic [31:0] word_t;

	localparam word_t KEY_SYNC = 32'h4A78B9F2;
	localparam word_t XOR_SYNC = 32'hCD0031F7;

	// empty receive cycles needed before sync starts
	localparam int PURGE_CYCLES    = 20000;
	localparam int PURGE_CNT_WIDTH = $clog2(PURGE_CYCLES + 1);

	// ------------------------------------------------------------
	// command word layout
	// ------------------------------------------------------------
	localparam int    WRITE_FLAG_BIT = 12;
	localparam int    COUNT_FLAG_BIT = 13;
	// bits 23..14, unsupported flags
	localparam word_t FLAG_FIELD     = 32'h00FF_C000;
	localparam int    COUNT_WIDTH    = 12;

	typedef enum logic [1:0] {
		PURGE,
		SYNC,
		RUN
	} link_state_e;

	typedef enum logic [3:0] {
		IDLE,
		COMMAND,
		ADDRESS,
		STEP,
		FETCH_DATA,
		ACCESS,
		RETURN_DATA,
		ACKNOWLEDGE,
		ERROR
	} seq_state_e;

endpackage
